// File: lru_cache.f
lru_cache_pkg.sv
lru_line_controller.sv
cache_tag_store.sv
cache_data_store.sv
cache_controller.sv
lru_cache_top.sv
tb_wb_memory.sv
tb_lru_cache.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_lru_cache -f lru_cache.f -o tb_lru_cache

./obj_dir/tb_lru_cache | tee sim.log

# the log decides the result
if grep -q "All checks passed" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

// File: tb_lru_cache.sv
`timescale 1ns/1ps

module tb_lru_cache;

	localparam int N_WAYS     = lru_cache_pkg::DEFAULT_N_WAYS;
	localparam int N_SETS     = lru_cache_pkg::DEFAULT_N_SETS;
	localparam int DATA_WIDTH = lru_cache_pkg::DEFAULT_DATA_WIDTH;
	localparam int ADDR_WIDTH = lru_cache_pkg::DEFAULT_ADDR_WIDTH;
	localparam int INDEX_W    = $clog2(N_SETS);
	localparam int TAG_W      = ADDR_WIDTH - INDEX_W;
	localparam int MAX_DELAY  = 5;
	localparam logic [DATA_WIDTH-1:0] DATA_KEY = 32'hc3a5_0f96;
	localparam int N_ROWS     = 23;
	// worst row plus margin, and the reset cycles
	localparam int CYCLE_LIMIT = N_ROWS * (MAX_DELAY + 10) + 8;

	logic                  clock;
	logic                  resetn;
	logic                  s_cyc;
	logic                  s_stb;
	logic [ADDR_WIDTH-1:0] s_adr;
	logic [DATA_WIDTH-1:0] s_dat;
	logic                  s_ack;
	logic                  m_cyc;
	logic                  m_stb;
	logic [ADDR_WIDTH-1:0] m_adr;
	logic [DATA_WIDTH-1:0] m_dat;
	logic                  m_ack;
	int                    read_count;

	// stimulus table, hit column worked out by hand
	string                 row_name [N_ROWS];
	logic [ADDR_WIDTH-1:0] row_addr [N_ROWS];
	bit                    row_hit  [N_ROWS];

	// reference model, per set tags in use order, slot 0 is mru
	logic [TAG_W-1:0]      model_tag  [N_SETS][N_WAYS];
	int                    model_fill [N_SETS];

	int errors = 0;
	int cycles = 0;

	lru_cache_top #(
		.N_WAYS     (N_WAYS),
		.N_SETS     (N_SETS),
		.DATA_WIDTH (DATA_WIDTH),
		.ADDR_WIDTH (ADDR_WIDTH)
	) lru_cache_top_i (
		.clock_i  (clock),
		.resetn_i (resetn),
		.s_cyc_i  (s_cyc),
		.s_stb_i  (s_stb),
		.s_adr_i  (s_adr),
		.s_dat_o  (s_dat),
		.s_ack_o  (s_ack),
		.m_cyc_o  (m_cyc),
		.m_stb_o  (m_stb),
		.m_adr_o  (m_adr),
		.m_dat_i  (m_dat),
		.m_ack_i  (m_ack)
	);

	tb_wb_memory #(
		.ADDR_WIDTH (ADDR_WIDTH),
		.DATA_WIDTH (DATA_WIDTH),
		.MAX_DELAY  (MAX_DELAY),
		.DATA_KEY   (DATA_KEY)
	) wb_memory_i (
		.clock_i      (clock),
		.resetn_i     (resetn),
		.cyc_i        (m_cyc),
		.stb_i        (m_stb),
		.adr_i        (m_adr),
		.dat_o        (m_dat),
		.ack_o        (m_ack),
		.read_count_o (read_count)
	);

	// --------------------
	// clock and timeout
	// --------------------

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	always @(posedge clock) begin
		cycles = cycles + 1;
		if (cycles == CYCLE_LIMIT) begin
			$display("Timeout: the cache did not finish the table within %0d cycles", CYCLE_LIMIT);
			$display("Checks failed");
			$finish;
		end
	end

	// --------------------
	// table and model
	// --------------------

	task automatic set_row(input int r, input string name, input logic [ADDR_WIDTH-1:0] addr,
	                       input bit hit);
		row_name[r] = name;
		row_addr[r] = addr;
		row_hit[r]  = hit;
	endtask

	task automatic fill_table();
		// cold misses then repeats, sets 0 and 5
		set_row(0,  "cold_a",        16'h0010, 1'b0);
		set_row(1,  "cold_a_again",  16'h0010, 1'b1);
		set_row(2,  "cold_b",        16'h0025, 1'b0);
		set_row(3,  "cold_b_again",  16'h0025, 1'b1);
		// four tags fill set 3, then all hit
		set_row(4,  "fill_way0",     16'h000b, 1'b0);
		set_row(5,  "fill_way1",     16'h0013, 1'b0);
		set_row(6,  "fill_way2",     16'h001b, 1'b0);
		set_row(7,  "fill_way3",     16'h0023, 1'b0);
		set_row(8,  "hit_way0",      16'h000b, 1'b1);
		set_row(9,  "hit_way1",      16'h0013, 1'b1);
		set_row(10, "hit_way2",      16'h001b, 1'b1);
		set_row(11, "hit_way3",      16'h0023, 1'b1);
		// touch two, tag 0x13 is now lru and gets evicted
		set_row(12, "touch_0b",      16'h000b, 1'b1);
		set_row(13, "touch_1b",      16'h001b, 1'b1);
		set_row(14, "evict_lru",     16'h002b, 1'b0);
		set_row(15, "keep_0b",       16'h000b, 1'b1);
		set_row(16, "keep_1b",       16'h001b, 1'b1);
		set_row(17, "keep_23",       16'h0023, 1'b1);
		set_row(18, "evicted_13",    16'h0013, 1'b0);
		// other sets untouched by set 3 traffic
		set_row(19, "iso_set0",      16'h0010, 1'b1);
		set_row(20, "same_tag_set4", 16'h0014, 1'b0);
		set_row(21, "iso_set0_again", 16'h0010, 1'b1);
		set_row(22, "iso_set5",      16'h0025, 1'b1);
	endtask

	// true lru on tags, a hit or a fill moves the tag to the front
	task automatic model_access(input logic [ADDR_WIDTH-1:0] addr, output bit hit);
		int               set_n;
		int               pos;
		logic [TAG_W-1:0] tag;
		set_n = int'(addr[INDEX_W-1:0]);
		tag   = addr[ADDR_WIDTH-1:INDEX_W];
		pos   = model_fill[set_n];
		hit   = 1'b0;
		for (int k = 0; k < model_fill[set_n]; k++) begin
			if (model_tag[set_n][k] == tag) begin
				hit = 1'b1;
				pos = k;
			end
		end
		// full set drops the oldest tag
		if (!hit && pos == N_WAYS) begin
			pos = N_WAYS - 1;
		end else if (!hit) begin
			model_fill[set_n] = model_fill[set_n] + 1;
		end
		for (int k = N_WAYS - 1; k > 0; k--) begin
			if (k <= pos) begin
				model_tag[set_n][k] = model_tag[set_n][k-1];
			end
		end
		model_tag[set_n][0] = tag;
	endtask

	// --------------------
	// stimulus and checks
	// --------------------

	initial begin
		int                    reads_before;
		int                    n_cycles;
		int                    exp_inc;
		int                    passed;
		bit                    exp_hit;
		bit                    row_ok;
		logic [DATA_WIDTH-1:0] exp_data;
		passed = 0;
		s_cyc  = 1'b0;
		s_stb  = 1'b0;
		s_adr  = '0;
		resetn = 1'b0;
		fill_table();
		for (int s = 0; s < N_SETS; s++) begin
			model_fill[s] = 0;
		end
		repeat (4) @(negedge clock);
		resetn = 1'b1;

		for (int r = 0; r < N_ROWS; r++) begin
			row_ok = 1'b1;
			model_access(row_addr[r], exp_hit);
			if (exp_hit != row_hit[r]) begin
				$display("%s: table expects hit %0d but the replacement rule gives %0d",
				         row_name[r], row_hit[r], exp_hit);
				row_ok = 1'b0;
				errors++;
			end
			exp_data = DATA_WIDTH'(row_addr[r]) ^ DATA_KEY;
			exp_inc  = exp_hit ? 0 : 1;

			@(negedge clock);
			reads_before = read_count;
			s_cyc = 1'b1;
			s_stb = 1'b1;
			s_adr = row_addr[r];
			n_cycles = 0;
			// hold the request until ack, memory must stay idle on hits
			do begin
				@(negedge clock);
				n_cycles++;
				if (exp_hit && (m_cyc || m_stb)) begin
					$display("%s: memory cycle started on a hit", row_name[r]);
					row_ok = 1'b0;
					errors++;
				end
				// a refill reads the requested word address
				if (m_stb && m_adr !== row_addr[r]) begin
					$display("CHECK FAILED %s memory address expected %h actual %h", row_name[r],
					         row_addr[r], m_adr);
					row_ok = 1'b0;
					errors++;
				end
			end while (!s_ack);

			if (s_dat !== exp_data) begin
				$display("CHECK FAILED %s data expected %h actual %h", row_name[r], exp_data, s_dat);
				row_ok = 1'b0;
				errors++;
			end
			if (read_count - reads_before != exp_inc) begin
				$display("CHECK FAILED %s memory reads expected %0d actual %0d", row_name[r],
				         exp_inc, read_count - reads_before);
				row_ok = 1'b0;
				errors++;
			end
			if (exp_hit && n_cycles != 3) begin
				$display("CHECK FAILED %s hit latency expected 3 actual %0d", row_name[r], n_cycles);
				row_ok = 1'b0;
				errors++;
			end

			// cycle stays open through the ack edge, then ends
			@(negedge clock);
			s_cyc = 1'b0;
			s_stb = 1'b0;
			if (s_ack) begin
				$display("%s: ack stayed high for more than one cycle", row_name[r]);
				row_ok = 1'b0;
				errors++;
			end
			if (row_ok) begin
				passed++;
			end
			$display("%-16s addr %h %s %s", row_name[r], row_addr[r], exp_hit ? "hit " : "miss",
			         row_ok ? "ok" : "FAILED");
		end

		$display("rows %0d, passed %0d, failed %0d, errors %0d", N_ROWS, passed, N_ROWS - passed,
		         errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// File: tb_wb_memory.sv
`timescale 1ns/1ps

module tb_wb_memory #(
	parameter int ADDR_WIDTH = lru_cache_pkg::DEFAULT_ADDR_WIDTH,
	parameter int DATA_WIDTH = lru_cache_pkg::DEFAULT_DATA_WIDTH,
	parameter int MAX_DELAY  = 5,
	parameter logic [DATA_WIDTH-1:0] DATA_KEY = 32'hc3a5_0f96
)(
	input  logic                  clock_i,
	input  logic                  resetn_i,
	// wishbone classic slave
	input  logic                  cyc_i,
	input  logic                  stb_i,
	input  logic [ADDR_WIDTH-1:0] adr_i,
	output logic [DATA_WIDTH-1:0] dat_o,
	output logic                  ack_o,
	// completed reads since reset
	output int                    read_count_o
);

	// fixed seed so every run sees the same delays
	integer seed = 32'hab90cc78;

	// wait states for the current read and how many have passed
	int   delay_q;
	int   wait_q;
	logic ack_q;

	assign ack_o = ack_q;

	always @(posedge clock_i) begin
		if (!resetn_i) begin
			ack_q        <= 1'b0;
			wait_q       <= 0;
			read_count_o <= 0;
			dat_o        <= '0;
			delay_q      <= int'($unsigned($random(seed)) % (MAX_DELAY + 1));
		end else if (ack_q) begin
			// single cycle ack, the master drops stb at this edge
			ack_q <= 1'b0;
		end else if (cyc_i && stb_i) begin
			if (wait_q >= delay_q) begin
				ack_q        <= 1'b1;
				// word is the address xor a fixed key
				dat_o        <= DATA_WIDTH'(adr_i) ^ DATA_KEY;
				read_count_o <= read_count_o + 1;
				wait_q       <= 0;
				// new delay for the next read
				delay_q      <= int'($unsigned($random(seed)) % (MAX_DELAY + 1));
			end else begin
				wait_q <= wait_q + 1;
			end
		end
	end

endmodule

// File: lru_cache_top.sv
`timescale 1ns/1ps

module lru_cache_top #(
	parameter int N_WAYS     = lru_cache_pkg::DEFAULT_N_WAYS,
	parameter int N_SETS     = lru_cache_pkg::DEFAULT_N_SETS,
	parameter int DATA_WIDTH = lru_cache_pkg::DEFAULT_DATA_WIDTH,
	parameter int ADDR_WIDTH = lru_cache_pkg::DEFAULT_ADDR_WIDTH,
	localparam int INDEX_W   = $clog2(N_SETS),
	localparam int TAG_W     = ADDR_WIDTH - INDEX_W,
	localparam int WAY_W     = $clog2(N_WAYS)
)(
	input  logic                  clock_i,
	input  logic                  resetn_i,
	// cpu slave port
	input  logic                  s_cyc_i,
	input  logic                  s_stb_i,
	input  logic [ADDR_WIDTH-1:0] s_adr_i,
	output logic [DATA_WIDTH-1:0] s_dat_o,
	output logic                  s_ack_o,
	// memory master port
	output logic                  m_cyc_o,
	output logic                  m_stb_o,
	output logic [ADDR_WIDTH-1:0] m_adr_o,
	input  logic [DATA_WIDTH-1:0] m_dat_i,
	input  logic                  m_ack_i
);

	logic [INDEX_W-1:0]    index;
	logic [TAG_W-1:0]      tag;
	logic                  hit;
	logic [WAY_W-1:0]      hit_way;
	logic                  tag_wr;
	logic [WAY_W-1:0]      way;
	logic                  data_wr;
	logic [DATA_WIDTH-1:0] fill_q;

	logic                  lru_enable;
	logic                  lru_hit;
	logic                  lru_miss;
	logic [WAY_W-1:0]      lru_way;
	logic                  lru_done;
	logic [WAY_W-1:0]      lru_victim;

	// per set lru outputs
	logic [N_SETS-1:0]     set_done;
	logic [WAY_W-1:0]      set_victim [N_SETS];

	// capture the fetched word, written to the data store in UPDATE
	always_ff @(posedge clock_i) begin
		if (m_cyc_o && m_ack_i) begin
			fill_q <= m_dat_i;
		end
	end

	// --------------------
	// sequencer
	// --------------------

	cache_controller #(
		.DATA_WIDTH (DATA_WIDTH),
		.ADDR_WIDTH (ADDR_WIDTH),
		.N_WAYS     (N_WAYS),
		.N_SETS     (N_SETS)
	) cache_controller_i (
		.clock_i      (clock_i),
		.resetn_i     (resetn_i),
		.s_cyc_i      (s_cyc_i),
		.s_stb_i      (s_stb_i),
		.s_adr_i      (s_adr_i),
		.s_ack_o      (s_ack_o),
		.m_cyc_o      (m_cyc_o),
		.m_stb_o      (m_stb_o),
		.m_adr_o      (m_adr_o),
		.m_ack_i      (m_ack_i),
		.index_o      (index),
		.tag_o        (tag),
		.hit_i        (hit),
		.hit_way_i    (hit_way),
		.tag_wr_o     (tag_wr),
		.way_o        (way),
		.data_wr_o    (data_wr),
		.lru_enable_o (lru_enable),
		.lru_hit_o    (lru_hit),
		.lru_miss_o   (lru_miss),
		.lru_way_o    (lru_way),
		.lru_done_i   (lru_done),
		.lru_victim_i (lru_victim)
	);

	// --------------------
	// stores
	// --------------------

	cache_tag_store #(
		.N_WAYS     (N_WAYS),
		.N_SETS     (N_SETS),
		.ADDR_WIDTH (ADDR_WIDTH)
	) cache_tag_store_i (
		.clock_i   (clock_i),
		.resetn_i  (resetn_i),
		.index_i   (index),
		.tag_i     (tag),
		.wr_i      (tag_wr),
		.wr_way_i  (way),
		.hit_o     (hit),
		.hit_way_o (hit_way)
	);

	// read data goes straight out to the cpu
	cache_data_store #(
		.N_WAYS     (N_WAYS),
		.N_SETS     (N_SETS),
		.DATA_WIDTH (DATA_WIDTH)
	) cache_data_store_i (
		.clock_i (clock_i),
		.index_i (index),
		.way_i   (way),
		.wr_i    (data_wr),
		.wdata_i (fill_q),
		.rdata_o (s_dat_o)
	);

	// --------------------
	// lru per set
	// --------------------

	// only the indexed set sees the hit and miss pulses
	for (genvar s = 0; s < N_SETS; s++) begin : g_set
		lru_line_controller #(
			.N_LOCATIONS (N_WAYS)
		) lru_line_controller_i (
			.clock_i  (clock_i),
			.resetn_i (resetn_i),
			.enable_i (lru_enable && (index == INDEX_W'(s))),
			.addr_i   (lru_way),
			.hit_i    (lru_hit),
			.miss_i   (lru_miss),
			.done_o   (set_done[s]),
			.addr_o   (set_victim[s])
		);
	end

	// victim and done of the selected set back to the controller
	assign lru_done   = set_done[index];
	assign lru_victim = set_victim[index];

endmodule

// File: cache_controller.sv
`timescale 1ns/1ps

module cache_controller #(
	parameter int DATA_WIDTH = lru_cache_pkg::DEFAULT_DATA_WIDTH,
	parameter int ADDR_WIDTH = lru_cache_pkg::DEFAULT_ADDR_WIDTH,
	parameter int N_WAYS     = lru_cache_pkg::DEFAULT_N_WAYS,
	parameter int N_SETS     = lru_cache_pkg::DEFAULT_N_SETS,
	localparam int INDEX_W   = $clog2(N_SETS),
	localparam int TAG_W     = ADDR_WIDTH - INDEX_W,
	localparam int WAY_W     = $clog2(N_WAYS)
)(
	input  logic                  clock_i,
	input  logic                  resetn_i,
	// cpu side, wishbone classic slave
	input  logic                  s_cyc_i,
	input  logic                  s_stb_i,
	input  logic [ADDR_WIDTH-1:0] s_adr_i,
	output logic                  s_ack_o,
	// memory side, wishbone classic master
	output logic                  m_cyc_o,
	output logic                  m_stb_o,
	output logic [ADDR_WIDTH-1:0] m_adr_o,
	input  logic                  m_ack_i,
	// tag store
	output logic [INDEX_W-1:0]    index_o,
	output logic [TAG_W-1:0]      tag_o,
	input  logic                  hit_i,
	input  logic [WAY_W-1:0]      hit_way_i,
	output logic                  tag_wr_o,
	// data store
	output logic [WAY_W-1:0]      way_o,
	output logic                  data_wr_o,
	// lru controllers
	output logic                  lru_enable_o,
	output logic                  lru_hit_o,
	output logic                  lru_miss_o,
	output logic [WAY_W-1:0]      lru_way_o,
	input  logic                  lru_done_i,
	input  logic [WAY_W-1:0]      lru_victim_i
);

	// geometry sanity, the tag needs at least one bit
	if (ADDR_WIDTH <= INDEX_W || DATA_WIDTH < 1) begin : g_bad_geometry
		$error("cache_controller: address too narrow for the set count or empty data word");
	end

	lru_cache_pkg::ctrl_state_e state_q, state_d;

	// latched request and chosen way
	logic [ADDR_WIDTH-1:0] addr_q;
	logic [WAY_W-1:0]      way_q;
	logic                  ack_q;
	logic                  m_req_q;
	logic                  accept;
	logic                  refill_start;

	// --------------------
	// next state
	// --------------------

	// no new request while the ack of the last one is still out
	assign accept = s_cyc_i && s_stb_i && !ack_q;

	// victim is valid once the lru controller reports done
	assign refill_start = (state_q == lru_cache_pkg::REFILL) && !m_req_q && lru_done_i;

	always_comb begin
		state_d = state_q;
		case (state_q)
			lru_cache_pkg::IDLE: begin
				if (accept) begin
					state_d = lru_cache_pkg::LOOKUP;
				end
			end
			lru_cache_pkg::LOOKUP: begin
				state_d = hit_i ? lru_cache_pkg::RESPOND : lru_cache_pkg::REFILL;
			end
			lru_cache_pkg::REFILL: begin
				// memory may take any number of cycles
				if (m_req_q && m_ack_i) begin
					state_d = lru_cache_pkg::UPDATE;
				end
			end
			lru_cache_pkg::UPDATE:  state_d = lru_cache_pkg::RESPOND;
			lru_cache_pkg::RESPOND: state_d = lru_cache_pkg::IDLE;
			default:                state_d = lru_cache_pkg::IDLE;
		endcase
	end

	// --------------------
	// registers
	// --------------------

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q <= lru_cache_pkg::IDLE;
			ack_q   <= 1'b0;
			m_req_q <= 1'b0;
		end else begin
			state_q <= state_d;
			// ack lands in the cycle after RESPOND, with the read data
			ack_q   <= (state_q == lru_cache_pkg::RESPOND);
			// single beat read, held until the slave acks
			if (refill_start) begin
				m_req_q <= 1'b1;
			end else if (m_req_q && m_ack_i) begin
				m_req_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock_i) begin
		if (state_q == lru_cache_pkg::IDLE && accept) begin
			addr_q <= s_adr_i;
		end
		// hit way from the compare, or victim from the lru stack
		if (state_q == lru_cache_pkg::LOOKUP && hit_i) begin
			way_q <= hit_way_i;
		end else if (refill_start) begin
			way_q <= lru_victim_i;
		end
	end

	// --------------------
	// outputs
	// --------------------

	assign s_ack_o = ack_q;

	assign m_cyc_o = m_req_q;
	assign m_stb_o = m_req_q;
	assign m_adr_o = addr_q;

	assign index_o = addr_q[INDEX_W-1:0];
	assign tag_o   = addr_q[ADDR_WIDTH-1:INDEX_W];

	// refill commit
	assign tag_wr_o  = (state_q == lru_cache_pkg::UPDATE);
	assign data_wr_o = (state_q == lru_cache_pkg::UPDATE);
	assign way_o     = way_q;

	// lru pulses, the fill in UPDATE counts as a use
	assign lru_enable_o = (state_q == lru_cache_pkg::LOOKUP) || (state_q == lru_cache_pkg::UPDATE);
	assign lru_hit_o    = ((state_q == lru_cache_pkg::LOOKUP) && hit_i) ||
	                      (state_q == lru_cache_pkg::UPDATE);
	assign lru_miss_o   = (state_q == lru_cache_pkg::LOOKUP) && !hit_i;
	assign lru_way_o    = (state_q == lru_cache_pkg::LOOKUP) ? hit_way_i : way_q;

	// cpu must hold the cycle open until it sees the ack
	a_ack_in_cycle: assert property (
		@(posedge clock_i) disable iff (!resetn_i)
		s_ack_o |-> s_cyc_i
	);

	// master strobe and its address stay put until the memory answers
	a_stb_held: assert property (
		@(posedge clock_i) disable iff (!resetn_i)
		(m_stb_o && !m_ack_i) |=> (m_stb_o && $stable(m_adr_o))
	);

endmodule

// File: cache_data_store.sv
`timescale 1ns/1ps

module cache_data_store #(
	parameter int N_WAYS     = lru_cache_pkg::DEFAULT_N_WAYS,
	parameter int N_SETS     = lru_cache_pkg::DEFAULT_N_SETS,
	parameter int DATA_WIDTH = lru_cache_pkg::DEFAULT_DATA_WIDTH,
	localparam int INDEX_W   = $clog2(N_SETS),
	localparam int WAY_W     = $clog2(N_WAYS)
)(
	input  logic                  clock_i,
	input  logic [INDEX_W-1:0]    index_i,
	input  logic [WAY_W-1:0]      way_i,
	input  logic                  wr_i,
	input  logic [DATA_WIDTH-1:0] wdata_i,
	output logic [DATA_WIDTH-1:0] rdata_o
);

	// one word per line, addressed by set and way
	logic [DATA_WIDTH-1:0] mem_q [N_SETS][N_WAYS];
	logic [DATA_WIDTH-1:0] rdata_q;

	assign rdata_o = rdata_q;

	// --------------------
	// write port
	// --------------------

	// refill writes the fetched word
	always_ff @(posedge clock_i) begin
		if (wr_i) begin
			mem_q[index_i][way_i] <= wdata_i;
		end
	end

	// --------------------
	// read port
	// --------------------

	// registered read, one cycle latency
	// a read in the write cycle sees the old word
	always_ff @(posedge clock_i) begin
		rdata_q <= mem_q[index_i][way_i];
	end

endmodule

// File: cache_tag_store.sv
`timescale 1ns/1ps

module cache_tag_store #(
	parameter int N_WAYS     = lru_cache_pkg::DEFAULT_N_WAYS,
	parameter int N_SETS     = lru_cache_pkg::DEFAULT_N_SETS,
	parameter int ADDR_WIDTH = lru_cache_pkg::DEFAULT_ADDR_WIDTH,
	localparam int INDEX_W   = $clog2(N_SETS),
	localparam int TAG_W     = ADDR_WIDTH - INDEX_W,
	localparam int WAY_W     = $clog2(N_WAYS)
)(
	input  logic               clock_i,
	input  logic               resetn_i,
	input  logic [INDEX_W-1:0] index_i,
	input  logic [TAG_W-1:0]   tag_i,
	input  logic               wr_i,
	input  logic [WAY_W-1:0]   wr_way_i,
	output logic               hit_o,
	output logic [WAY_W-1:0]   hit_way_o
);

	// tag per set and way, valid bits per set
	logic [TAG_W-1:0]  tag_q [N_SETS][N_WAYS];
	logic [N_WAYS-1:0] valid_q [N_SETS];
	logic [N_WAYS-1:0] match;

	// --------------------
	// storage
	// --------------------

	always_ff @(posedge clock_i) begin
		if (wr_i) begin
			tag_q[index_i][wr_way_i] <= tag_i;
		end
	end

	// all lines invalid after reset, a refill sets its way valid
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			for (int s = 0; s < N_SETS; s++) begin
				valid_q[s] <= '0;
			end
		end else if (wr_i) begin
			valid_q[index_i][wr_way_i] <= 1'b1;
		end
	end

	// --------------------
	// lookup
	// --------------------

	// compare the tag against every way of the indexed set
	always_comb begin
		for (int w = 0; w < N_WAYS; w++) begin
			match[w] = valid_q[index_i][w] && (tag_q[index_i][w] == tag_i);
		end
	end

	assign hit_o = |match;

	// encode the matching way
	always_comb begin
		hit_way_o = '0;
		for (int w = 0; w < N_WAYS; w++) begin
			if (match[w]) begin
				hit_way_o = WAY_W'(w);
			end
		end
	end

	// a tag is only ever filled into one way of a set
	a_single_match: assert property (
		@(posedge clock_i) disable iff (!resetn_i)
		$onehot0(match)
	);

endmodule

// File: lru_line_controller.sv
`timescale 1ns/1ps

module lru_line_controller #(
	parameter int N_LOCATIONS = lru_cache_pkg::DEFAULT_N_WAYS,
	localparam int BW_LOC = $clog2(N_LOCATIONS)
)(
	input  logic              clock_i,
	input  logic              resetn_i,
	// only the set being accessed is enabled
	input  logic              enable_i,
	input  logic [BW_LOC-1:0] addr_i,
	input  logic              hit_i,
	input  logic              miss_i,
	output logic              done_o,
	output logic [BW_LOC-1:0] addr_o
);

	// fill counter needs one extra bit to count up to N_LOCATIONS
	localparam int CNT_W = BW_LOC + 1;
	localparam logic [CNT_W-1:0] FILL_MAX = CNT_W'(N_LOCATIONS);

	// --------------------
	// lru stack
	// --------------------

	// one ordinal position per way, 0 is mru, all ones is lru
	// the positions always form a permutation of 0..N_LOCATIONS-1
	logic [BW_LOC-1:0]      stack_q [N_LOCATIONS];
	logic [BW_LOC-1:0]      match_pos;
	logic [N_LOCATIONS-1:0] lru_bits;
	logic [BW_LOC-1:0]      lru_way;

	// cold start fill count and registered outputs
	logic [CNT_W-1:0]       fill_cnt_q;
	logic                   fill_done;
	logic                   done_q;
	logic [BW_LOC-1:0]      addr_q;

	assign done_o = done_q;
	assign addr_o = addr_q;

	// position of the way that was just used
	assign match_pos = stack_q[addr_i];

	// every way has been filled once since reset
	assign fill_done = (fill_cnt_q == FILL_MAX);

	// only the lru position reduces to one
	for (genvar k = 0; k < N_LOCATIONS; k++) begin : g_reduce
		assign lru_bits[k] = &stack_q[k];
	end

	// priority encode the reduction, lowest way wins
	always_comb begin
		lru_way = '0;
		for (int k = N_LOCATIONS - 1; k >= 0; k--) begin
			if (lru_bits[k]) begin
				lru_way = BW_LOC'(k);
			end
		end
	end

	// --------------------
	// update
	// --------------------

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			fill_cnt_q <= '0;
			done_q     <= 1'b0;
			addr_q     <= '0;
			// identity order, way N-1 starts as lru
			for (int i = 0; i < N_LOCATIONS; i++) begin
				stack_q[i] <= BW_LOC'(i);
			end
		end else begin
			// single cycle update, so always ready once out of reset
			done_q <= 1'b1;

			if (enable_i) begin
				// used way becomes mru, more recent ways age by one
				if (hit_i) begin
					for (int i = 0; i < N_LOCATIONS; i++) begin
						if (BW_LOC'(i) == addr_i) begin
							stack_q[i] <= '0;
						end else if (stack_q[i] < match_pos) begin
							stack_q[i] <= stack_q[i] + 1'b1;
						end
					end
				end

				// pick the victim for the refill
				if (miss_i) begin
					if (fill_done) begin
						addr_q <= lru_way;
					end else begin
						// cold start, hand out ways in order
						addr_q     <= fill_cnt_q[BW_LOC-1:0];
						fill_cnt_q <= fill_cnt_q + 1'b1;
					end
				end
			end
		end
	end

	// the controller never reports both outcomes for one access
	a_hit_miss_excl: assert property (
		@(posedge clock_i) disable iff (!resetn_i)
		enable_i |-> !(hit_i && miss_i)
	);

endmodule

// File: lru_cache_pkg.sv
package lru_cache_pkg;

	// --------------------
	// default geometry
	// --------------------

	// ways per set
	parameter int DEFAULT_N_WAYS = 4;

	// number of sets, must be a power of two
	parameter int DEFAULT_N_SETS = 8;

	// width of one cached word
	parameter int DEFAULT_DATA_WIDTH = 32;

	// word address width on both bus ports
	parameter int DEFAULT_ADDR_WIDTH = 16;

	// --------------------
	// controller states
	// --------------------

	// IDLE     wait for a cpu request and latch its address
	// LOOKUP   tag compare, hit or miss pulse to the lru controller
	// REFILL   single beat read on the memory master port
	// UPDATE   write tag, valid and data, mark the filled way as mru
	// RESPOND  read the line out and register the cpu ack
	typedef enum logic [2:0] {
		IDLE    = 3'd0,
		LOOKUP  = 3'd1,
		REFILL  = 3'd2,
		UPDATE  = 3'd3,
		RESPOND = 3'd4
	} ctrl_state_e;

endpackage
